// File: Bender.yml
package:
  name: rv_core

sources:
  - hdl/rvCorePkg.sv
  - hdl/rvDecoder.sv
  - hdl/rvAlu.sv
  - hdl/rvCsrFile.sv
  - hdl/rvRegFile.sv
  - hdl/rvIdExWb.sv
  - hdl/rvFetch.sv
  - hdl/rvCoreTop.sv
  - target: test
    files:
      - tests/tbRvMem.sv
      - tests/tbRvCore.sv

// File: hdl/rvAlu.sv
/*
 * RV32I ALU with the branch comparator alongside
 */
`timescale 1ns/10ps

module rvAlu (
  input  rvCorePkg::word_t  a,
  input  rvCorePkg::word_t  b,
  input  rvCorePkg::aluOp_t aluOp,
  output rvCorePkg::word_t  aluOut,
  input  rvCorePkg::word_t  brA,
  input  rvCorePkg::word_t  brB,
  input  logic              brUn,
  output logic              brEq,
  output logic              brLt
);
  import rvCorePkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (aluOp)
      ALU_ADD: aluOut = a + b;
      ALU_SUB: aluOut = a - b;
      ALU_SLL: aluOut = a << shamt;
      ALU_SLT: aluOut = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: aluOut = {31'b0, a < b};
      ALU_XOR: aluOut = a ^ b;
      ALU_SRL: aluOut = a >> shamt;
      ALU_SRA: aluOut = $signed(a) >>> shamt;
      ALU_OR: aluOut = a | b;
      ALU_AND: aluOut = a & b;
      ALU_PASSB: aluOut = b;
      default: aluOut = '0;
    endcase
  end

  // compare on the raw register operands, not the ALU inputs
  assign brEq = (brA == brB);
  assign brLt = brUn ? (brA < brB) : ($signed(brA) < $signed(brB));

endmodule

// File: hdl/rvCorePkg.sv
/*
 * RV32I core package with word and index types, instruction field codes,
 * datapath select codes and the fetch FSM states
 */
package rvCorePkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [11:0] csrAddr_t;
  typedef logic [3:0]  aluOp_t;
  typedef logic [1:0]  wbSel_t;
  typedef logic [2:0]  memExt_t;
  typedef logic [2:0]  immSel_t;

  typedef enum logic [1:0] {FETCH_REQ, FETCH_WAIT, FETCH_HALT} fetchState_t;

  localparam word_t RESET_PC = 32'h80000000;
  localparam word_t MCAUSE_ECALL = 32'd11;

  // major opcodes
  localparam logic [6:0] OP_LUI = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam aluOp_t ALU_ADD = 4'd0;
  localparam aluOp_t ALU_SUB = 4'd1;
  localparam aluOp_t ALU_SLL = 4'd2;
  localparam aluOp_t ALU_SLT = 4'd3;
  localparam aluOp_t ALU_SLTU = 4'd4;
  localparam aluOp_t ALU_XOR = 4'd5;
  localparam aluOp_t ALU_SRL = 4'd6;
  localparam aluOp_t ALU_SRA = 4'd7;
  localparam aluOp_t ALU_OR = 4'd8;
  localparam aluOp_t ALU_AND = 4'd9;
  localparam aluOp_t ALU_PASSB = 4'd10;

  localparam wbSel_t WB_MEM = 2'd0;
  localparam wbSel_t WB_ALU = 2'd1;
  localparam wbSel_t WB_PC4 = 2'd2;
  localparam wbSel_t WB_CSR = 2'd3;

  // load extension codes
  localparam memExt_t EXT_WORD = 3'd0;
  localparam memExt_t EXT_SB = 3'd1;
  localparam memExt_t EXT_SH = 3'd2;
  localparam memExt_t EXT_UB = 3'd3;
  localparam memExt_t EXT_UH = 3'd4;

  localparam immSel_t IMM_I = 3'd0;
  localparam immSel_t IMM_S = 3'd1;
  localparam immSel_t IMM_B = 3'd2;
  localparam immSel_t IMM_U = 3'd3;
  localparam immSel_t IMM_J = 3'd4;

  // ALU operand B sources
  localparam logic [1:0] BSEL_REG = 2'd0;
  localparam logic [1:0] BSEL_IMM = 2'd1;
  localparam logic [1:0] BSEL_CSR = 2'd2;

  // csr operations match funct3[1:0]
  localparam logic [1:0] CSR_RW = 2'b01;
  localparam logic [1:0] CSR_RS = 2'b10;
  localparam logic [1:0] CSR_RC = 2'b11;

  localparam csrAddr_t CSR_MSTATUS = 12'h300;
  localparam csrAddr_t CSR_MTVEC = 12'h305;
  localparam csrAddr_t CSR_MEPC = 12'h341;
  localparam csrAddr_t CSR_MCAUSE = 12'h342;

endpackage

// File: hdl/rvCoreTop.sv
/*
 * RV32I core top: fetch unit, execute stage and register file
 */
`timescale 1ns/10ps

module rvCoreTop (
  input  logic             clk,
  input  logic             rst,
  output logic             imemReq,
  output rvCorePkg::word_t imemAddr,
  input  logic             imemValid,
  input  rvCorePkg::word_t imemData,
  output logic             dmemRead,
  output logic             dmemWrite,
  output rvCorePkg::word_t dmemAddr,
  output rvCorePkg::word_t dmemWdata,
  output logic [3:0]       dmemWmask,
  input  rvCorePkg::word_t dmemRdata,
  output logic             retire,
  output rvCorePkg::word_t traceDnpc,
  output logic             halted
);
  import rvCorePkg::*;

  word_t   inst, pc, dnpc, regDataWb, regData1, regData2;
  regIdx_t rd, rs1, rs2;
  logic    ifuValid, regWrite, halt;

  rvFetch uFetch (
    .clk(clk), .rst(rst), .imemReq(imemReq), .imemAddr(imemAddr),
    .imemValid(imemValid), .imemData(imemData), .dnpc(dnpc), .halt(halt),
    .ifuValid(ifuValid), .inst(inst), .pc(pc), .halted(halted)
  );

  rvIdExWb uStage (
    .clk(clk), .rst(rst), .ifuValid(ifuValid), .inst(inst), .pc(pc),
    .rd(rd), .rs1(rs1), .rs2(rs2), .regWrite(regWrite), .regDataWb(regDataWb),
    .regData1(regData1), .regData2(regData2), .dmemRead(dmemRead),
    .dmemWrite(dmemWrite), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
    .dmemWmask(dmemWmask), .dmemRdata(dmemRdata), .dnpc(dnpc), .halt(halt)
  );

  rvRegFile uRegFile (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .wen(regWrite),
    .wdata(regDataWb), .rdata1(regData1), .rdata2(regData2)
  );

  // trace outputs for the testbench
  assign retire = ifuValid;
  assign traceDnpc = dnpc;

endmodule

// File: hdl/rvCsrFile.sv
/*
 * machine-mode CSRs with csrrw/csrrs/csrrc and ecall/mret handling
 */
`timescale 1ns/10ps

module rvCsrFile (
  input  logic                clk,
  input  logic                rst,
  input  logic                csrEn,
  input  logic [1:0]          csrOp,
  input  rvCorePkg::csrAddr_t csrId,
  input  rvCorePkg::word_t    src,
  output rvCorePkg::word_t    rdata,
  input  logic                ecall,
  input  logic                mret,
  input  rvCorePkg::word_t    pc,
  output rvCorePkg::word_t    mtvec,
  output rvCorePkg::word_t    mepc
);
  import rvCorePkg::*;

  word_t mstatusQ, mtvecQ, mepcQ, mcauseQ;
  word_t wdata;

  always_comb begin
    case (csrId)
      CSR_MSTATUS: rdata = mstatusQ;
      CSR_MTVEC: rdata = mtvecQ;
      CSR_MEPC: rdata = mepcQ;
      CSR_MCAUSE: rdata = mcauseQ;
      default: rdata = '0;
    endcase
  end

  always_comb begin
    case (csrOp)
      CSR_RW: wdata = src;
      CSR_RS: wdata = rdata | src;
      CSR_RC: wdata = rdata & ~src;
      default: wdata = rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatusQ <= 32'h00001800;
      mtvecQ <= '0;
      mepcQ <= '0;
      mcauseQ <= '0;
    end else if (ecall) begin
      mepcQ <= pc;
      mcauseQ <= MCAUSE_ECALL;
      // MPIE takes MIE, MIE cleared
      mstatusQ[7] <= mstatusQ[3];
      mstatusQ[3] <= 1'b0;
    end else if (mret) begin
      mstatusQ[3] <= mstatusQ[7];
      mstatusQ[7] <= 1'b1;
    end else if (csrEn) begin
      case (csrId)
        CSR_MSTATUS: mstatusQ <= wdata;
        CSR_MTVEC: mtvecQ <= wdata;
        CSR_MEPC: mepcQ <= wdata;
        CSR_MCAUSE: mcauseQ <= wdata;
        default: mcauseQ <= mcauseQ;
      endcase
    end
  end

  assign mtvec = mtvecQ;
  assign mepc = mepcQ;

endmodule

// File: hdl/rvDecoder.sv
/*
 * RV32I decoder: control fields for the single-cycle stage,
 * immediate generation and branch resolution
 */
`timescale 1ns/10ps

module rvDecoder (
  input  rvCorePkg::word_t   inst,
  input  logic               brEq,
  input  logic               brLt,
  output logic               brUn,
  output logic               regWrite,
  output logic               memRead,
  output logic               memWrite,
  output logic [1:0]         memSize,
  output rvCorePkg::memExt_t memExt,
  output rvCorePkg::aluOp_t  aluOp,
  output logic               aluASel,
  output logic [1:0]         aluBSel,
  output rvCorePkg::wbSel_t  wbSel,
  output logic               pcSel,
  output logic               csrEn,
  output logic [1:0]         csrOp,
  output rvCorePkg::word_t   imm,
  output logic               ecall,
  output logic               mret,
  output logic               ebreak
);
  import rvCorePkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  immSel_t    immSel;
  aluOp_t     arithOp;
  logic       takeBranch;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign brUn = funct3[1];

  // inst[30] selects sub only for register ops, sra for both shift forms
  always_comb begin
    case (funct3)
      3'b000: arithOp = (opcode == OP_REG && inst[30]) ? ALU_SUB : ALU_ADD;
      3'b001: arithOp = ALU_SLL;
      3'b010: arithOp = ALU_SLT;
      3'b011: arithOp = ALU_SLTU;
      3'b100: arithOp = ALU_XOR;
      3'b101: arithOp = inst[30] ? ALU_SRA : ALU_SRL;
      3'b110: arithOp = ALU_OR;
      default: arithOp = ALU_AND;
    endcase
  end

  // beq/bne on equality, the rest on less-than
  assign takeBranch = funct3[2] ? (brLt ^ funct3[0]) : (brEq ^ funct3[0]);

  always_comb begin
    regWrite = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    memSize = funct3[1:0];
    memExt = EXT_WORD;
    aluOp = ALU_ADD;
    aluASel = 1'b0;
    aluBSel = BSEL_IMM;
    wbSel = WB_ALU;
    pcSel = 1'b0;
    csrEn = 1'b0;
    csrOp = funct3[1:0];
    immSel = IMM_I;
    ecall = 1'b0;
    mret = 1'b0;
    ebreak = 1'b0;
    case (opcode)
      OP_LUI: begin
        regWrite = 1'b1;
        aluOp = ALU_PASSB;
        immSel = IMM_U;
      end
      OP_AUIPC: begin
        regWrite = 1'b1;
        aluASel = 1'b1;
        immSel = IMM_U;
      end
      OP_JAL: begin
        regWrite = 1'b1;
        aluASel = 1'b1;
        immSel = IMM_J;
        wbSel = WB_PC4;
        pcSel = 1'b1;
      end
      OP_JALR: begin
        regWrite = 1'b1;
        wbSel = WB_PC4;
        pcSel = 1'b1;
      end
      OP_BRANCH: begin
        aluASel = 1'b1;
        immSel = IMM_B;
        pcSel = takeBranch;
      end
      OP_LOAD: begin
        regWrite = 1'b1;
        memRead = 1'b1;
        wbSel = WB_MEM;
        case (funct3)
          3'b000: memExt = EXT_SB;
          3'b001: memExt = EXT_SH;
          3'b100: memExt = EXT_UB;
          3'b101: memExt = EXT_UH;
          default: memExt = EXT_WORD;
        endcase
      end
      OP_STORE: begin
        memWrite = 1'b1;
        immSel = IMM_S;
      end
      OP_IMM: begin
        regWrite = 1'b1;
        aluOp = arithOp;
      end
      OP_REG: begin
        regWrite = 1'b1;
        aluOp = arithOp;
        aluBSel = BSEL_REG;
      end
      OP_MISC_MEM: begin
        // fence has no effect with a single in-order port
        regWrite = 1'b0;
      end
      OP_SYSTEM: begin
        if (funct3 == 3'b000) begin
          ecall = (inst[31:20] == 12'h000);
          ebreak = (inst[31:20] == 12'h001);
          mret = (inst[31:20] == 12'h302);
        end else if (!funct3[2]) begin
          // old csr value goes through the ALU unchanged
          regWrite = 1'b1;
          csrEn = 1'b1;
          aluOp = ALU_PASSB;
          aluBSel = BSEL_CSR;
          wbSel = WB_CSR;
        end
      end
      default: regWrite = 1'b0;
    endcase
  end

  always_comb begin
    case (immSel)
      IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      IMM_U: imm = {inst[31:12], 12'b0};
      IMM_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = {{20{inst[31]}}, inst[31:20]};
    endcase
  end

endmodule

// File: hdl/rvFetch.sv
/*
 * fetch unit with the program counter and a request/wait/halt FSM
 * for a variable-latency instruction port
 */
`timescale 1ns/10ps

module rvFetch (
  input  logic             clk,
  input  logic             rst,
  output logic             imemReq,
  output rvCorePkg::word_t imemAddr,
  input  logic             imemValid,
  input  rvCorePkg::word_t imemData,
  input  rvCorePkg::word_t dnpc,
  input  logic             halt,
  output logic             ifuValid,
  output rvCorePkg::word_t inst,
  output rvCorePkg::word_t pc,
  output logic             halted
);
  import rvCorePkg::*;

  fetchState_t state;
  word_t       pcQ;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FETCH_REQ;
      pcQ <= RESET_PC;
    end else begin
      case (state)
        FETCH_REQ: state <= FETCH_WAIT;
        FETCH_WAIT: begin
          if (imemValid) begin
            if (halt) begin
              state <= FETCH_HALT;
            end else begin
              pcQ <= dnpc;
              state <= FETCH_REQ;
            end
          end
        end
        default: state <= FETCH_HALT;
      endcase
    end
  end

  // first request in the first cycle after reset
  assign imemReq = (state == FETCH_REQ) && !rst;
  assign imemAddr = pcQ;
  assign ifuValid = (state == FETCH_WAIT) && imemValid;
  assign inst = imemData;
  assign pc = pcQ;
  assign halted = (state == FETCH_HALT);

  aRespOnlyWaiting: assert property (@(posedge clk) disable iff (rst)
    imemValid |-> state == FETCH_WAIT)
    else $error("instruction response without an outstanding request");

  aAddrStable: assert property (@(posedge clk) disable iff (rst)
    (state == FETCH_WAIT && !imemValid) |=> $stable(imemAddr))
    else $error("fetch address changed while waiting");

endmodule

// File: hdl/rvIdExWb.sv
/*
 * decode, execute, memory access and writeback in the ifuValid cycle,
 * plus next-pc selection for the fetch unit
 */
`timescale 1ns/10ps

module rvIdExWb (
  input  logic               clk,
  input  logic               rst,
  input  logic               ifuValid,
  input  rvCorePkg::word_t   inst,
  input  rvCorePkg::word_t   pc,
  output rvCorePkg::regIdx_t rd,
  output rvCorePkg::regIdx_t rs1,
  output rvCorePkg::regIdx_t rs2,
  output logic               regWrite,
  output rvCorePkg::word_t   regDataWb,
  input  rvCorePkg::word_t   regData1,
  input  rvCorePkg::word_t   regData2,
  output logic               dmemRead,
  output logic               dmemWrite,
  output rvCorePkg::word_t   dmemAddr,
  output rvCorePkg::word_t   dmemWdata,
  output logic [3:0]         dmemWmask,
  input  rvCorePkg::word_t   dmemRdata,
  output rvCorePkg::word_t   dnpc,
  output logic               halt
);
  import rvCorePkg::*;

  word_t   imm, aluA, aluB, aluOut, csrRdata, mtvec, mepc, snpc, target;
  word_t   loadShift, loadData;
  logic    decRegWrite, memRead, memWrite, brUn, brEq, brLt;
  logic    aluASel, pcSel, csrEn, ecall, mret, ebreak;
  logic [1:0] memSize, aluBSel, csrOp;
  memExt_t memExt;
  aluOp_t  aluOp;
  wbSel_t  wbSel;

  assign rd = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  rvDecoder uDecoder (
    .inst(inst), .brEq(brEq), .brLt(brLt), .brUn(brUn),
    .regWrite(decRegWrite), .memRead(memRead), .memWrite(memWrite),
    .memSize(memSize), .memExt(memExt), .aluOp(aluOp), .aluASel(aluASel),
    .aluBSel(aluBSel), .wbSel(wbSel), .pcSel(pcSel), .csrEn(csrEn),
    .csrOp(csrOp), .imm(imm), .ecall(ecall), .mret(mret), .ebreak(ebreak)
  );

  rvCsrFile uCsrFile (
    .clk(clk), .rst(rst), .csrEn(csrEn & ifuValid), .csrOp(csrOp),
    .csrId(inst[31:20]), .src(regData1), .rdata(csrRdata),
    .ecall(ecall & ifuValid), .mret(mret & ifuValid), .pc(pc),
    .mtvec(mtvec), .mepc(mepc)
  );

  assign aluA = aluASel ? pc : regData1;
  assign aluB = (aluBSel == BSEL_REG) ? regData2 :
                (aluBSel == BSEL_CSR) ? csrRdata : imm;

  rvAlu uAlu (
    .a(aluA), .b(aluB), .aluOp(aluOp), .aluOut(aluOut),
    .brA(regData1), .brB(regData2), .brUn(brUn), .brEq(brEq), .brLt(brLt)
  );

  // data port, strobes only live in the ifuValid cycle
  assign dmemAddr = aluOut;
  assign dmemRead = memRead & ifuValid;
  assign dmemWrite = memWrite & ifuValid;
  assign dmemWdata = regData2 << {aluOut[1:0], 3'b000};
  assign dmemWmask = ((memSize == 2'd0) ? 4'b0001 :
                      (memSize == 2'd1) ? 4'b0011 : 4'b1111) << aluOut[1:0];

  // bring the addressed lane down to bit 0 before extending
  assign loadShift = dmemRdata >> {aluOut[1:0], 3'b000};

  always_comb begin
    case (memExt)
      EXT_SB: loadData = {{24{loadShift[7]}}, loadShift[7:0]};
      EXT_SH: loadData = {{16{loadShift[15]}}, loadShift[15:0]};
      EXT_UB: loadData = {24'b0, loadShift[7:0]};
      EXT_UH: loadData = {16'b0, loadShift[15:0]};
      default: loadData = dmemRdata;
    endcase
  end

  assign snpc = pc + 32'd4;

  always_comb begin
    case (wbSel)
      WB_MEM: regDataWb = loadData;
      WB_PC4: regDataWb = snpc;
      WB_CSR: regDataWb = csrRdata;
      default: regDataWb = aluOut;
    endcase
  end

  assign regWrite = decRegWrite & ifuValid;
  assign halt = ebreak & ifuValid;

  // jalr needs bit 0 cleared, the other targets are even already
  assign target = {aluOut[31:1], 1'b0};
  assign dnpc = !ifuValid ? pc :
                mret      ? mepc :
                ecall     ? mtvec :
                pcSel     ? target : snpc;

  aNoLoadStore: assert property (@(posedge clk) disable iff (rst)
    !(dmemRead && dmemWrite))
    else $error("load and store strobes high together");

endmodule

// File: hdl/rvRegFile.sv
/*
 * integer register file, two combinational reads and one write, x0 fixed at zero
 */
`timescale 1ns/10ps

module rvRegFile (
  input  logic               clk,
  input  logic               rst,
  input  rvCorePkg::regIdx_t rs1,
  input  rvCorePkg::regIdx_t rs2,
  input  rvCorePkg::regIdx_t rd,
  input  logic               wen,
  input  rvCorePkg::word_t   wdata,
  output rvCorePkg::word_t   rdata1,
  output rvCorePkg::word_t   rdata2
);
  import rvCorePkg::*;

  // x1..x31 only
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: tb.f
hdl/rvCorePkg.sv
hdl/rvDecoder.sv
hdl/rvAlu.sv
hdl/rvCsrFile.sv
hdl/rvRegFile.sv
hdl/rvIdExWb.sv
hdl/rvFetch.sv
hdl/rvCoreTop.sv
tests/tbRvMem.sv
tests/tbRvCore.sv

// File: tests/tbRvCore.sv
/*
 * directed testbench for the RV32I core with hand-assembled programs,
 * store log and retire trace checks
 */
`timescale 1ns/10ps

module tbRvCore;
  import rvCorePkg::*;

  // arith twice, mem, branch, trap and halt programs
  localparam int TOTAL_INSTS = 33 + 18 + 13 + 17 + 33 + 3;
  localparam int CYCLE_LIMIT = 40 * TOTAL_INSTS;

  localparam logic [6:0] IMM_OPC = 7'b0010011;
  localparam logic [6:0] LOAD_OPC = 7'b0000011;
  localparam logic [6:0] JALR_OPC = 7'b1100111;
  localparam logic [6:0] SYS_OPC = 7'b1110011;
  localparam logic [6:0] LUI_OPC = 7'b0110111;
  localparam logic [6:0] AUIPC_OPC = 7'b0010111;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  logic       imemReq, imemValid, dmemRead, dmemWrite, retire, halted;
  word_t      imemAddr, imemData, dmemAddr, dmemWdata, dmemRdata, traceDnpc;
  logic [3:0] dmemWmask;
  int         progLen = 0;
  int         errors = 0;
  int         cycles = 0;
  word_t      trace [0:63];
  int         traceCount = 0;
  int         loadCount = 0;

  rvCoreTop u_dut (
    .clk(clk), .rst(rst), .imemReq(imemReq), .imemAddr(imemAddr),
    .imemValid(imemValid), .imemData(imemData), .dmemRead(dmemRead),
    .dmemWrite(dmemWrite), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
    .dmemWmask(dmemWmask), .dmemRdata(dmemRdata), .retire(retire),
    .traceDnpc(traceDnpc), .halted(halted)
  );

  tbRvMem u_mem (
    .clk(clk), .rst(rst), .progLen(progLen), .imemReq(imemReq),
    .imemAddr(imemAddr), .imemValid(imemValid), .imemData(imemData),
    .dmemWrite(dmemWrite), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
    .dmemWmask(dmemWmask), .dmemRdata(dmemRdata)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d errors so far", CYCLE_LIMIT, errors);
      $display("** FAIL **");
      $finish;
    end
  end

  // next pc of every retired instruction
  always @(posedge clk) begin
    if (rst) begin
      traceCount = 0;
    end else if (retire && traceCount < 64) begin
      trace[traceCount] = traceDnpc;
      traceCount = traceCount + 1;
    end
  end

  // cycles with the load strobe up
  always @(posedge clk) begin
    if (rst) begin
      loadCount = 0;
    end else if (dmemRead) begin
      loadCount = loadCount + 1;
    end
  end

  // instruction encoders
  function automatic word_t regOp(input logic [6:0] f7, input regIdx_t rs2,
                                  input regIdx_t rs1, input logic [2:0] f3,
                                  input regIdx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t immOp(input logic [11:0] imm, input regIdx_t rs1,
                                  input logic [2:0] f3, input regIdx_t rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t storeOp(input logic [11:0] imm, input regIdx_t rs2,
                                    input regIdx_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t branchOp(input logic [12:0] imm, input regIdx_t rs2,
                                     input regIdx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t upperOp(input logic [19:0] imm, input regIdx_t rd,
                                    input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t jumpOp(input logic [20:0] imm, input regIdx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input word_t w);
    u_mem.prog[progLen] = w;
    progLen++;
  endtask

  task automatic resetCore();
    @(posedge clk);
    rst <= 1'b1;
    progLen = 0;
  endtask

  task automatic runToHalt();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    do @(posedge clk); while (!halted);
  endtask

  task automatic checkWord(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic checkMask(input string name, input logic [3:0] exp,
                           input logic [3:0] act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic checkPc(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic checkStoreCount(input int n);
    if (u_mem.logCount != n) begin
      $display("at %0t the core made %0d stores instead of %0d", $time, u_mem.logCount, n);
      errors++;
    end
  endtask

  task automatic verifyLoadCount(input int n);
    if (loadCount != n) begin
      $display("at %0t the core raised dmemRead %0d times instead of %0d", $time,
               loadCount, n);
      errors++;
    end
  endtask

  task automatic expectStore(input int idx, input word_t addr, input word_t data,
                             input logic [3:0] mask);
    if (idx < u_mem.logCount) begin
      checkWord($sformatf("store %0d dmemAddr", idx), addr, u_mem.logAddr[idx]);
      checkWord($sformatf("store %0d dmemWdata", idx), data, u_mem.logData[idx]);
      checkMask($sformatf("store %0d dmemWmask", idx), mask, u_mem.logMask[idx]);
    end
  endtask

  task automatic arithTest();
    word_t exp [0:14];
    exp = '{32'd93, 32'hFFFFFF95, 32'hFFFFFF90, 32'hF, 32'hFFFFFFFC, 32'd1, 32'd0,
            32'hFFFFFF9D, 32'hFFFFFFFD, 32'hF0, 32'h320000, 32'hFFFFFFFF,
            32'h12345000, RESET_PC + 32'h3C + 32'h1000, 32'd0};
    resetCore();
    emit(immOp(12'd100, 0, 3'b000, 1, IMM_OPC));
    // x2 = -7
    emit(immOp(12'hFF9, 0, 3'b000, 2, IMM_OPC));
    emit(regOp(7'h00, 2, 1, 3'b000, 3));
    emit(regOp(7'h20, 1, 2, 3'b000, 4));
    emit(immOp(12'd4, 2, 3'b001, 5, IMM_OPC));
    emit(immOp(12'd28, 2, 3'b101, 6, IMM_OPC));
    emit(immOp(12'h401, 2, 3'b101, 7, IMM_OPC));
    emit(regOp(7'h00, 1, 2, 3'b010, 8));
    emit(regOp(7'h00, 1, 2, 3'b011, 9));
    emit(regOp(7'h00, 2, 1, 3'b100, 10));
    emit(regOp(7'h00, 2, 1, 3'b110, 11));
    emit(immOp(12'h0F0, 2, 3'b111, 12, IMM_OPC));
    emit(regOp(7'h00, 6, 1, 3'b001, 13));
    emit(regOp(7'h20, 6, 2, 3'b101, 14));
    emit(upperOp(20'h12345, 15, LUI_OPC));
    emit(upperOp(20'h00001, 16, AUIPC_OPC));
    emit(immOp(12'd5, 0, 3'b000, 0, IMM_OPC));
    for (int r = 3; r <= 16; r++) begin
      emit(storeOp(12'(32'h100 + 4 * (r - 3)), 5'(r), 0, 3'b010));
    end
    emit(storeOp(12'h138, 0, 0, 3'b010));
    emit(32'h00100073);
    runToHalt();
    checkStoreCount(15);
    verifyLoadCount(0);
    for (int i = 0; i < 15; i++) begin
      expectStore(i, 32'h100 + 4 * i, exp[i], 4'hF);
    end
  endtask

  task automatic memTest();
    word_t exp [0:5];
    exp = '{32'hFFFFFFEF, 32'hEF, 32'hFFFFCDEF, 32'hCDEF, 32'hCDEFEF00, 32'd0};
    resetCore();
    // x1 = 0x89abcdef
    emit(upperOp(20'h89ABD, 1, LUI_OPC));
    emit(immOp(12'hDEF, 1, 3'b000, 1, IMM_OPC));
    emit(storeOp(12'h140, 0, 0, 3'b010));
    emit(storeOp(12'h141, 1, 0, 3'b000));
    emit(storeOp(12'h142, 1, 0, 3'b001));
    emit(immOp(12'h141, 0, 3'b000, 2, LOAD_OPC));
    emit(immOp(12'h142, 0, 3'b100, 3, LOAD_OPC));
    emit(immOp(12'h142, 0, 3'b001, 4, LOAD_OPC));
    emit(immOp(12'h142, 0, 3'b101, 5, LOAD_OPC));
    emit(immOp(12'h140, 0, 3'b010, 6, LOAD_OPC));
    emit(immOp(12'h140, 0, 3'b000, 7, LOAD_OPC));
    for (int r = 2; r <= 7; r++) begin
      emit(storeOp(12'(32'h150 + 4 * (r - 2)), 5'(r), 0, 3'b010));
    end
    emit(32'h00100073);
    runToHalt();
    checkStoreCount(9);
    verifyLoadCount(6);
    expectStore(0, 32'h140, 32'd0, 4'b1111);
    expectStore(1, 32'h141, 32'hABCDEF00, 4'b0010);
    expectStore(2, 32'h142, 32'hCDEF0000, 4'b1100);
    for (int i = 0; i < 6; i++) begin
      expectStore(3 + i, 32'h150 + 4 * i, exp[i], 4'hF);
    end
  endtask

  task automatic branchTest();
    int nextIdx [0:12];
    nextIdx = '{1, 2, 4, 5, 7, 8, 11, 12, 16, 17, 18, 19, 20};
    resetCore();
    emit(immOp(12'd5, 0, 3'b000, 1, IMM_OPC));
    emit(immOp(12'hFFD, 0, 3'b000, 2, IMM_OPC));
    emit(branchOp(13'd8, 1, 1, 3'b000));
    emit(immOp(12'd1, 0, 3'b000, 10, IMM_OPC));
    emit(branchOp(13'd8, 1, 1, 3'b001));
    emit(branchOp(13'd8, 1, 2, 3'b100));
    emit(immOp(12'd2, 0, 3'b000, 10, IMM_OPC));
    emit(branchOp(13'd8, 2, 1, 3'b111));
    emit(jumpOp(21'd12, 3));
    emit(immOp(12'd3, 0, 3'b000, 10, IMM_OPC));
    emit(immOp(12'd4, 0, 3'b000, 10, IMM_OPC));
    emit(upperOp(20'h0, 4, AUIPC_OPC));
    // odd offset whose bit 0 the target drops
    emit(immOp(12'd21, 4, 3'b000, 5, JALR_OPC));
    for (int i = 0; i < 3; i++) begin
      emit(immOp(12'd5, 0, 3'b000, 10, IMM_OPC));
    end
    emit(storeOp(12'h160, 3, 0, 3'b010));
    emit(storeOp(12'h164, 5, 0, 3'b010));
    emit(storeOp(12'h168, 10, 0, 3'b010));
    emit(32'h00100073);
    runToHalt();
    checkStoreCount(3);
    expectStore(0, 32'h160, RESET_PC + 32'd36, 4'hF);
    expectStore(1, 32'h164, RESET_PC + 32'd52, 4'hF);
    expectStore(2, 32'h168, 32'd0, 4'hF);
    if (traceCount != 13) begin
      $display("at %0t the core retired %0d instructions instead of 13", $time, traceCount);
      errors++;
    end
    for (int i = 0; i < 13; i++) begin
      checkPc($sformatf("retire %0d traceDnpc", i), RESET_PC + word_t'(4 * nextIdx[i]),
              trace[i]);
    end
  endtask

  task automatic trapTest();
    resetCore();
    emit(upperOp(20'h0, 1, AUIPC_OPC));
    emit(immOp(12'd32, 1, 3'b000, 1, IMM_OPC));
    emit(immOp(12'h305, 1, 3'b001, 0, SYS_OPC));
    emit(immOp(12'd7, 0, 3'b000, 2, IMM_OPC));
    emit(32'h00000073);
    emit(immOp(12'd1, 2, 3'b000, 2, IMM_OPC));
    emit(storeOp(12'h17C, 2, 0, 3'b010));
    emit(32'h00100073);
    // handler at index 8
    emit(immOp(12'h341, 0, 3'b010, 3, SYS_OPC));
    emit(immOp(12'h342, 0, 3'b010, 4, SYS_OPC));
    emit(storeOp(12'h170, 3, 0, 3'b010));
    emit(storeOp(12'h174, 4, 0, 3'b010));
    emit(immOp(12'd4, 3, 3'b000, 3, IMM_OPC));
    emit(immOp(12'h341, 3, 3'b001, 0, SYS_OPC));
    emit(immOp(12'h305, 0, 3'b010, 5, SYS_OPC));
    emit(storeOp(12'h178, 5, 0, 3'b010));
    emit(32'h30200073);
    runToHalt();
    checkStoreCount(4);
    expectStore(0, 32'h170, RESET_PC + 32'd16, 4'hF);
    expectStore(1, 32'h174, 32'd11, 4'hF);
    expectStore(2, 32'h178, RESET_PC + 32'd32, 4'hF);
    expectStore(3, 32'h17C, 32'd8, 4'hF);
    checkPc("ecall traceDnpc", RESET_PC + 32'd32, trace[4]);
    checkPc("mret traceDnpc", RESET_PC + 32'd20, trace[13]);
  endtask

  task automatic haltTest();
    int  reqs;
    logic stayed;
    stayed = 1'b1;
    resetCore();
    emit(immOp(12'd42, 0, 3'b000, 1, IMM_OPC));
    emit(storeOp(12'h180, 1, 0, 3'b010));
    emit(32'h00100073);
    // must never be fetched
    emit(storeOp(12'h184, 1, 0, 3'b010));
    runToHalt();
    reqs = u_mem.reqCount;
    repeat (20) begin
      @(posedge clk);
      stayed = stayed & halted;
    end
    if (!stayed) begin
      $display("at %0t halted dropped after ebreak", $time);
      errors++;
    end
    if (u_mem.reqCount != reqs || reqs != 3) begin
      $display("at %0t the core fetched %0d times, 3 expected", $time, u_mem.reqCount);
      errors++;
    end
    checkStoreCount(1);
    expectStore(0, 32'h180, 32'd42, 4'hF);
  endtask

  initial begin
    arithTest();
    memTest();
    branchTest();
    trapTest();
    // same program again under other fetch latencies
    arithTest();
    haltTest();
    $display("tbRvCore finished with %0d errors", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: tests/tbRvMem.sv
/*
 * memory model for the core testbench: instruction port with random
 * latency, combinational data reads and a log of every store
 */
`timescale 1ns/10ps

module tbRvMem (
  input  logic             clk,
  input  logic             rst,
  input  int               progLen,
  input  logic             imemReq,
  input  rvCorePkg::word_t imemAddr,
  output logic             imemValid,
  output rvCorePkg::word_t imemData,
  input  logic             dmemWrite,
  input  rvCorePkg::word_t dmemAddr,
  input  rvCorePkg::word_t dmemWdata,
  input  logic [3:0]       dmemWmask,
  output rvCorePkg::word_t dmemRdata
);
  import rvCorePkg::*;

  localparam word_t EBREAK = 32'h00100073;
  localparam word_t DATA_BASE = 32'h00000100;

  word_t      prog [0:63];
  word_t      dmem [0:63];
  word_t      logAddr [0:31];
  word_t      logData [0:31];
  logic [3:0] logMask [0:31];
  int         logCount;
  int         reqCount;
  word_t      reqAddr;
  word_t      offset;
  logic       pending;
  int unsigned delay;
  bit         seeded = 1'b0;

  initial begin
    imemValid = 1'b0;
    imemData = '0;
    // preload depends on the full byte address of each word
    for (int i = 0; i < 64; i++) begin
      dmem[i] = ~(DATA_BASE + 4 * i) ^ 32'h5a5a0000;
    end
  end

  assign offset = reqAddr - RESET_PC;
  assign dmemRdata = dmem[dmemAddr[7:2]];

  always @(posedge clk) begin
    if (!seeded) begin
      // one seed for the whole latency stream
      void'($urandom(32'hbfaa));
      seeded = 1'b1;
    end
    imemValid <= 1'b0;
    if (rst) begin
      pending <= 1'b0;
      logCount <= 0;
      reqCount <= 0;
    end else begin
      if (imemReq) begin
        pending <= 1'b1;
        reqAddr <= imemAddr;
        delay <= $urandom % 4;
        reqCount <= reqCount + 1;
      end else if (pending) begin
        if (delay == 0) begin
          // past the loaded program the core only sees ebreak
          imemValid <= 1'b1;
          imemData <= (offset < 4 * progLen) ? prog[offset[7:2]] : EBREAK;
          pending <= 1'b0;
        end else begin
          delay <= delay - 1;
        end
      end
      if (dmemWrite && logCount < 32) begin
        logAddr[logCount] <= dmemAddr;
        logData[logCount] <= dmemWdata;
        logMask[logCount] <= dmemWmask;
        logCount <= logCount + 1;
        for (int b = 0; b < 4; b++) begin
          if (dmemWmask[b]) begin
            dmem[dmemAddr[7:2]][8 * b +: 8] <= dmemWdata[8 * b +: 8];
          end
        end
      end
    end
  end

endmodule
